//--- Bender.yml
package:
  name: dcache

sources:
  - dcache_pkg.sv
  - dcache_dpram.sv
  - dcache_lookup.sv
  - dcache_ctrl.sv
  - dcache_top.sv
  - target: test
    files:
      - dcache_checker.sv
      - tb_dcache.sv

//--- dcache_checker.sv
`timescale 1ns/1ps

module dcache_checker (
   input  logic                          clk,
   input  logic                          rst,
   input  logic                          ack_i,
   input  logic                          inv_ack_i,
   input  logic                          refill_req_i,
   input  logic [dcache_pkg::ADDR_W-1:0] refill_adr_i,
   input  logic [dcache_pkg::DATA_W-1:0] rdat_i,
   input  logic [8*12-1:0]               name_i,
   input  logic                          check_rdat_i,
   input  logic [dcache_pkg::DATA_W-1:0] exp_rdat_i,
   input  logic                          exp_refill_i,
   input  logic [dcache_pkg::ADDR_W-1:0] exp_base_i,
   output int                            err_cnt_o,
   output int                            done_cnt_o
);
   import dcache_pkg::*;

   // Refills seen since the last completed operation
   int   refill_cnt;
   logic refill_q;

   // Sampled at the falling edge where DUT outputs are stable
   always @(negedge clk) begin
      if (rst) begin
         refill_cnt = 0;
         refill_q   = 1'b0;
         err_cnt_o  = 0;
         done_cnt_o = 0;
      end else begin
         // A refill is counted once on its rising request
         if (refill_req_i && !refill_q) begin
            refill_cnt++;
         end
         refill_q = refill_req_i;

         // Block base held for the whole refill
         if (refill_req_i && (refill_adr_i !== exp_base_i)) begin
            $display("FAILED %s: refill_adr expected %h, actual %h",
                     name_i, exp_base_i, refill_adr_i);
            err_cnt_o++;
         end

         // Either ack closes the current table row
         if (ack_i || inv_ack_i) begin
            done_cnt_o++;
            // Read data only matters on a read ack
            if (check_rdat_i && ack_i && (rdat_i !== exp_rdat_i)) begin
               $display("FAILED %s: rdat expected %h, actual %h",
                        name_i, exp_rdat_i, rdat_i);
               err_cnt_o++;
            end
            if (refill_cnt != int'(exp_refill_i)) begin
               $display("FAILED %s: refills expected %0d, actual %0d",
                        name_i, int'(exp_refill_i), refill_cnt);
               err_cnt_o++;
            end
            refill_cnt = 0;
         end
      end
   end

endmodule

//--- dcache_ctrl.sv
`timescale 1ns/1ps

module dcache_ctrl (
   input  logic                                clk,
   input  logic                                rst,
   input  logic                                req_i,
   input  dcache_pkg::cpu_req_t                req_data_i,
   input  logic                                inv_i,
   input  logic [dcache_pkg::SET_W-1:0]        inv_index_i,
   input  logic                                hit_i,
   input  logic [dcache_pkg::NUM_WAYS-1:0]     way_hit_i,
   input  logic [dcache_pkg::DATA_W-1:0]       hit_dat_i,
   input  logic [dcache_pkg::NUM_WAYS-1:0]     victim_i,
   input  dcache_pkg::tag_line_t               tag_line_i,
   input  logic                                refill_valid_i,
   input  logic [dcache_pkg::DATA_W-1:0]       refill_dat_i,
   output logic                                tag_we_o,
   output logic [dcache_pkg::SET_W-1:0]        tag_waddr_o,
   output dcache_pkg::tag_line_t               tag_wline_o,
   output logic [dcache_pkg::NUM_WAYS-1:0]     way_we_o,
   output logic [dcache_pkg::WAY_ADDR_W-1:0]   way_waddr_o,
   output logic [dcache_pkg::DATA_W-1:0]       way_wdat_o,
   output logic                                ack_o,
   output logic                                inv_ack_o,
   output logic                                refill_req_o,
   output logic [dcache_pkg::ADDR_W-1:0]       refill_adr_o
);
   import dcache_pkg::*;

   ctrl_state_t         state_q;
   logic [SET_W-1:0]    sweep_cnt_q;
   logic [WORD_W-1:0]   word_cnt_q;
   logic [NUM_WAYS-1:0] victim_q;
   tag_line_t           line_q;

   logic [SET_W-1:0]    req_set;
   logic [WORD_W-1:0]   req_word;
   logic [TAG_W-1:0]    req_tag;
   logic                first_word;
   logic                last_word;
   logic [DATA_W-1:0]   merge_dat;
   tag_line_t           fill_line;

   // Request address fields
   assign req_set  = adr_set(req_data_i.adr);
   assign req_word = adr_word(req_data_i.adr);
   assign req_tag  = adr_tag(req_data_i.adr);

   // Refill word position
   assign first_word = refill_valid_i && (word_cnt_q == '0);
   assign last_word  = refill_valid_i && (word_cnt_q == WORD_W'(WORDS_PER_BLOCK - 1));

   // Memory side handshake
   assign refill_req_o = (state_q == REFILL);
   // Block base of the missing address
   assign refill_adr_o = {req_data_i.adr[ADDR_W-1:OFFS_W], {OFFS_W{1'b0}}};

   // CPU and invalidate acks are single-cycle pulses
   assign ack_o     = (state_q == LOOKUP) && hit_i;
   assign inv_ack_o = (state_q == INVAL);

   // Byte-lane merge of write data over the cached word
   always_comb begin
      for (int i = 0; i < BSEL_W; i++) begin
         merge_dat[8*i +: 8] = req_data_i.bsel[i] ? req_data_i.wdat[8*i +: 8]
                                                  : hit_dat_i[8*i +: 8];
      end
   end

   // Tag line written during refill, built from the line saved at the miss
   always_comb begin
      fill_line = line_q;
      if (last_word) begin
         // Victim becomes valid with the new tag, LRU points at the other way
         fill_line.lru = victim_q[0];
         if (victim_q[0]) begin
            fill_line.way0.valid = 1'b1;
            fill_line.way0.tag   = req_tag;
         end
         if (victim_q[1]) begin
            fill_line.way1.valid = 1'b1;
            fill_line.way1.tag   = req_tag;
         end
      end else begin
         // First word, the victim is dropped while its data is overwritten
         if (victim_q[0]) begin
            fill_line.way0.valid = 1'b0;
         end
         if (victim_q[1]) begin
            fill_line.way1.valid = 1'b0;
         end
      end
   end

   // State register and counters
   always_ff @(posedge clk) begin
      if (rst) begin
         state_q     <= SWEEP;
         sweep_cnt_q <= '0;
         word_cnt_q  <= '0;
      end else begin
         case (state_q)
            SWEEP: begin
               // One tag line cleared per cycle
               sweep_cnt_q <= sweep_cnt_q + 1'b1;
               if (sweep_cnt_q == SET_W'(NUM_SETS - 1)) begin
                  state_q <= IDLE;
               end
            end
            IDLE: begin
               // Invalidate wins over a pending request
               if (inv_i) begin
                  state_q <= INVAL;
               end else if (req_i) begin
                  state_q <= LOOKUP;
               end
            end
            LOOKUP: begin
               word_cnt_q <= '0;
               state_q    <= hit_i ? IDLE : REFILL;
            end
            REFILL: begin
               if (refill_valid_i) begin
                  word_cnt_q <= word_cnt_q + 1'b1;
                  // Back to IDLE, the repeated lookup then hits
                  if (last_word) begin
                     state_q <= IDLE;
                  end
               end
            end
            INVAL: begin
               state_q <= IDLE;
            end
            default: begin
               state_q <= IDLE;
            end
         endcase
      end
   end

   // Victim and tag line captured on a miss
   always_ff @(posedge clk) begin
      if ((state_q == LOOKUP) && !hit_i) begin
         victim_q <= victim_i;
         line_q   <= tag_line_i;
      end
   end

   // RAM write side
   always_comb begin
      tag_we_o    = 1'b0;
      tag_waddr_o = req_set;
      tag_wline_o = tag_line_i;
      way_we_o    = '0;
      way_waddr_o = {req_set, req_word};
      way_wdat_o  = merge_dat;
      case (state_q)
         SWEEP: begin
            tag_we_o    = 1'b1;
            tag_waddr_o = sweep_cnt_q;
            tag_wline_o = '0;
         end
         LOOKUP: begin
            if (hit_i) begin
               // LRU moves to the way that was not used
               tag_we_o        = 1'b1;
               tag_wline_o.lru = way_hit_i[0];
               if (req_data_i.we) begin
                  way_we_o = way_hit_i;
               end
            end
         end
         REFILL: begin
            if (refill_valid_i) begin
               way_we_o    = victim_q;
               way_waddr_o = {req_set, word_cnt_q};
               way_wdat_o  = refill_dat_i;
               tag_we_o    = first_word || last_word;
               tag_wline_o = fill_line;
            end
         end
         INVAL: begin
            // Whole set dropped, both ways and LRU
            tag_we_o    = 1'b1;
            tag_waddr_o = inv_index_i;
            tag_wline_o = '0;
         end
         default: begin
         end
      endcase
   end

endmodule

//--- dcache_dpram.sv
`timescale 1ns/1ps

module dcache_dpram #(
   parameter type payload_t = logic [31:0],
   parameter int  DEPTH_W   = 4
) (
   input  logic               clk,
   input  logic [DEPTH_W-1:0] raddr_i,
   input  logic [DEPTH_W-1:0] waddr_i,
   input  logic               we_i,
   input  payload_t           wdata_i,
   output payload_t           rdata_o
);

   // Storage array, contents undefined until written
   payload_t mem [2**DEPTH_W];

   // Write port
   always_ff @(posedge clk) begin
      if (we_i) begin
         mem[waddr_i] <= wdata_i;
      end
   end

   // Registered read port, old data on a same-edge collision
   always_ff @(posedge clk) begin
      rdata_o <= mem[raddr_i];
   end

endmodule

//--- dcache_lookup.sv
`timescale 1ns/1ps

module dcache_lookup (
   input  dcache_pkg::tag_line_t               tag_line_i,
   input  logic [dcache_pkg::DATA_W-1:0]       way0_dat_i,
   input  logic [dcache_pkg::DATA_W-1:0]       way1_dat_i,
   input  logic [dcache_pkg::TAG_W-1:0]        req_tag_i,
   output logic                                hit_o,
   output logic [dcache_pkg::NUM_WAYS-1:0]     way_hit_o,
   output logic [dcache_pkg::DATA_W-1:0]       hit_dat_o,
   output logic [dcache_pkg::NUM_WAYS-1:0]     victim_o
);
   import dcache_pkg::*;

   // Per-way views of the tag line and data words
   tag_entry_t        entry   [NUM_WAYS];
   logic [DATA_W-1:0] way_dat [NUM_WAYS];

   assign entry[0]   = tag_line_i.way0;
   assign entry[1]   = tag_line_i.way1;
   assign way_dat[0] = way0_dat_i;
   assign way_dat[1] = way1_dat_i;

   // Tag compare, only a valid entry can match
   always_comb begin
      for (int w = 0; w < NUM_WAYS; w++) begin
         way_hit_o[w] = entry[w].valid && (entry[w].tag == req_tag_i);
      end
   end

   assign hit_o = |way_hit_o;

   // Word of the hitting way
   // Zero when nothing hits, the controller ignores it then
   always_comb begin
      hit_dat_o = '0;
      for (int w = 0; w < NUM_WAYS; w++) begin
         if (way_hit_o[w]) begin
            hit_dat_o = way_dat[w];
         end
      end
   end

   // LRU bit to one-hot victim
   assign victim_o = NUM_WAYS'(1) << tag_line_i.lru;

endmodule

//--- dcache_pkg.sv
package dcache_pkg;

   // Geometry: 16 sets, 2 ways, 4 words of 32 bits per block
   localparam int ADDR_W          = 16;
   localparam int DATA_W          = 32;
   localparam int BSEL_W          = DATA_W / 8;
   localparam int OFFS_W          = 4;
   localparam int SET_W           = 4;
   localparam int NUM_SETS        = 16;
   localparam int WORDS_PER_BLOCK = 4;
   localparam int WORD_W          = 2;
   localparam int TAG_W           = ADDR_W - SET_W - OFFS_W;
   localparam int WAY_ADDR_W      = SET_W + WORD_W;
   localparam int NUM_WAYS        = 2;

   // One way's entry in the tag RAM
   typedef struct packed {
      logic             valid;
      logic [TAG_W-1:0] tag;
   } tag_entry_t;

   // Full tag RAM line, lru set means way1 is the next victim
   typedef struct packed {
      logic       lru;
      tag_entry_t way1;
      tag_entry_t way0;
   } tag_line_t;

   // CPU request, held stable by the requester until ack
   typedef struct packed {
      logic [ADDR_W-1:0] adr;
      logic              we;
      logic [BSEL_W-1:0] bsel;
      logic [DATA_W-1:0] wdat;
   } cpu_req_t;

   typedef enum logic [2:0] {SWEEP, IDLE, LOOKUP, REFILL, INVAL} ctrl_state_t;

   // Address field extraction
   function automatic logic [TAG_W-1:0] adr_tag(input logic [ADDR_W-1:0] adr);
      return adr[ADDR_W-1:SET_W+OFFS_W];
   endfunction

   function automatic logic [SET_W-1:0] adr_set(input logic [ADDR_W-1:0] adr);
      return adr[SET_W+OFFS_W-1:OFFS_W];
   endfunction

   function automatic logic [WORD_W-1:0] adr_word(input logic [ADDR_W-1:0] adr);
      return adr[OFFS_W-1:OFFS_W-WORD_W];
   endfunction

endpackage

//--- dcache_top.sv
`timescale 1ns/1ps

module dcache_top (
   input  logic                              clk,
   input  logic                              rst,
   input  logic                              req_i,
   input  dcache_pkg::cpu_req_t              req_data_i,
   output logic                              ack_o,
   output logic [dcache_pkg::DATA_W-1:0]     rdat_o,
   input  logic                              inv_i,
   input  logic [dcache_pkg::SET_W-1:0]      inv_index_i,
   output logic                              inv_ack_o,
   output logic                              refill_req_o,
   output logic [dcache_pkg::ADDR_W-1:0]     refill_adr_o,
   input  logic                              refill_valid_i,
   input  logic [dcache_pkg::DATA_W-1:0]     refill_dat_i
);
   import dcache_pkg::*;

   // Read side addresses come straight from the request
   logic [SET_W-1:0]      rd_set;
   logic [WAY_ADDR_W-1:0] rd_word_adr;

   // Tag RAM
   tag_line_t             tag_rline;
   tag_line_t             tag_wline;
   logic                  tag_we;
   logic [SET_W-1:0]      tag_waddr;

   // Data RAMs, one per way
   logic [NUM_WAYS-1:0]   way_we;
   logic [WAY_ADDR_W-1:0] way_waddr;
   logic [DATA_W-1:0]     way_wdat;
   logic [DATA_W-1:0]     way_rdat [NUM_WAYS];

   // Lookup results
   logic                  hit;
   logic [NUM_WAYS-1:0]   way_hit;
   logic [NUM_WAYS-1:0]   victim;
   logic [DATA_W-1:0]     hit_dat;

   assign rd_set      = adr_set(req_data_i.adr);
   assign rd_word_adr = {rd_set, adr_word(req_data_i.adr)};
   assign rdat_o      = hit_dat;

   dcache_dpram #(
      .payload_t (tag_line_t),
      .DEPTH_W   (SET_W)
   ) tag_ram_inst (
      .clk     (clk),
      .raddr_i (rd_set),
      .waddr_i (tag_waddr),
      .we_i    (tag_we),
      .wdata_i (tag_wline),
      .rdata_o (tag_rline)
   );

   for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
      dcache_dpram #(
         .payload_t (logic [DATA_W-1:0]),
         .DEPTH_W   (WAY_ADDR_W)
      ) data_ram_inst (
         .clk     (clk),
         .raddr_i (rd_word_adr),
         .waddr_i (way_waddr),
         .we_i    (way_we[w]),
         .wdata_i (way_wdat),
         .rdata_o (way_rdat[w])
      );
   end

   dcache_lookup lookup_inst (
      .tag_line_i (tag_rline),
      .way0_dat_i (way_rdat[0]),
      .way1_dat_i (way_rdat[1]),
      .req_tag_i  (adr_tag(req_data_i.adr)),
      .hit_o      (hit),
      .way_hit_o  (way_hit),
      .hit_dat_o  (hit_dat),
      .victim_o   (victim)
   );

   dcache_ctrl ctrl_inst (
      .clk            (clk),
      .rst            (rst),
      .req_i          (req_i),
      .req_data_i     (req_data_i),
      .inv_i          (inv_i),
      .inv_index_i    (inv_index_i),
      .hit_i          (hit),
      .way_hit_i      (way_hit),
      .hit_dat_i      (hit_dat),
      .victim_i       (victim),
      .tag_line_i     (tag_rline),
      .refill_valid_i (refill_valid_i),
      .refill_dat_i   (refill_dat_i),
      .tag_we_o       (tag_we),
      .tag_waddr_o    (tag_waddr),
      .tag_wline_o    (tag_wline),
      .way_we_o       (way_we),
      .way_waddr_o    (way_waddr),
      .way_wdat_o     (way_wdat),
      .ack_o          (ack_o),
      .inv_ack_o      (inv_ack_o),
      .refill_req_o   (refill_req_o),
      .refill_adr_o   (refill_adr_o)
   );

endmodule

//--- files.f
dcache_pkg.sv
dcache_dpram.sv
dcache_lookup.sv
dcache_ctrl.sv
dcache_top.sv
dcache_checker.sv
tb_dcache.sv

//--- tb_dcache.sv
`timescale 1ns/1ps

module tb_dcache;
   import dcache_pkg::*;

   // Cycles allowed for any single ack
   localparam int TIMEOUT_CYCLES = 200;

   typedef enum logic [1:0] {OP_READ, OP_WRITE, OP_INVAL} op_kind_t;

   // One table row with expected values worked out by hand
   typedef struct packed {
      logic [8*12-1:0]   name;
      op_kind_t          kind;
      logic [ADDR_W-1:0] adr;
      logic [BSEL_W-1:0] bsel;
      logic [DATA_W-1:0] wdat;
      logic [DATA_W-1:0] exp_rdat;
      logic              exp_refill;
   } op_row_t;

   logic              clk;
   logic              rst;
   logic              req_i;
   cpu_req_t          req_data;
   logic              ack_o;
   logic [DATA_W-1:0] rdat_o;
   logic              inv_i;
   logic [SET_W-1:0]  inv_index;
   logic              inv_ack_o;
   logic              refill_req_o;
   logic [ADDR_W-1:0] refill_adr_o;
   logic              refill_valid_i;
   logic [DATA_W-1:0] refill_dat_i;

   // Expected values handed to the checker
   logic [8*12-1:0]   cur_name;
   logic              check_rdat;
   logic [DATA_W-1:0] exp_rdat;
   logic              exp_refill;
   logic [ADDR_W-1:0] exp_base;
   int                err_cnt;
   int                done_cnt;
   int                timeout_cnt;

   op_row_t           ops[$];
   logic [31:0]       lfsr;

   dcache_top dcache_top_inst (
      .clk            (clk),
      .rst            (rst),
      .req_i          (req_i),
      .req_data_i     (req_data),
      .ack_o          (ack_o),
      .rdat_o         (rdat_o),
      .inv_i          (inv_i),
      .inv_index_i    (inv_index),
      .inv_ack_o      (inv_ack_o),
      .refill_req_o   (refill_req_o),
      .refill_adr_o   (refill_adr_o),
      .refill_valid_i (refill_valid_i),
      .refill_dat_i   (refill_dat_i)
   );

   dcache_checker checker_inst (
      .clk          (clk),
      .rst          (rst),
      .ack_i        (ack_o),
      .inv_ack_i    (inv_ack_o),
      .refill_req_i (refill_req_o),
      .refill_adr_i (refill_adr_o),
      .rdat_i       (rdat_o),
      .name_i       (cur_name),
      .check_rdat_i (check_rdat),
      .exp_rdat_i   (exp_rdat),
      .exp_refill_i (exp_refill),
      .exp_base_i   (exp_base),
      .err_cnt_o    (err_cnt),
      .done_cnt_o   (done_cnt)
   );

   // 20 ns clock
   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // Memory contents with the address in both halves
   function automatic logic [DATA_W-1:0] mem_word(input logic [ADDR_W-1:0] a);
      return 32'(a) * 32'h00010001 ^ 32'hA5A5A5A5;
   endfunction

   // Galois LFSR shifting right and toggling the mask when the output bit is set
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      logic [31:0] n;
      n = s >> 1;
      if (s[0]) begin
         n = n ^ 32'hD0000001;
      end
      return n;
   endfunction

   // Gap of 0 to 3 cycles with one LFSR step per bit
   task automatic next_gap(output int gap);
      gap = 0;
      for (int b = 0; b < 2; b++) begin
         gap  = (gap << 1) | int'(lfsr[0]);
         lfsr = lfsr_step(lfsr);
      end
   endtask

   // Refill responder sending one word per pulse in ascending order
   initial begin
      int busy;
      int word_idx;
      int gap;
      refill_valid_i = 1'b0;
      refill_dat_i   = '0;
      busy           = 0;
      word_idx       = 0;
      gap            = 0;
      lfsr           = 32'd74540;
      forever begin
         @(posedge clk);
         #2;
         refill_valid_i = 1'b0;
         if (rst) begin
            busy = 0;
         end else if (refill_req_o) begin
            // New block request
            if (busy == 0) begin
               busy     = 1;
               word_idx = 0;
               next_gap(gap);
            end
            if (gap > 0) begin
               gap--;
            end else begin
               refill_valid_i = 1'b1;
               refill_dat_i   = mem_word(refill_adr_o + ADDR_W'(4 * word_idx));
               word_idx++;
               next_gap(gap);
               if (word_idx == WORDS_PER_BLOCK) begin
                  busy = 0;
               end
            end
         end
      end
   end

   function automatic op_row_t make_row(input op_kind_t kind, input logic [15:0] adr,
                                        input logic [3:0] bsel, input logic [31:0] wdat,
                                        input logic [31:0] rdat, input logic refill,
                                        input logic [8*12-1:0] name);
      op_row_t r;
      r.name       = name;
      r.kind       = kind;
      r.adr        = adr;
      r.bsel       = bsel;
      r.wdat       = wdat;
      r.exp_rdat   = rdat;
      r.exp_refill = refill;
      return r;
   endfunction

   task automatic load_table();
      // Cold miss and then a hit in the same block of set 3
      ops.push_back(make_row(OP_READ,  16'h1234, 4'h0, 32'h0, 32'hB791B791, 1'b1, "rd_miss"));
      ops.push_back(make_row(OP_READ,  16'h123C, 4'h0, 32'h0, 32'hB799B799, 1'b0, "rd_hit"));
      // Lanes 0 and 2 merged over the cached word
      ops.push_back(make_row(OP_WRITE, 16'h1234, 4'h5, 32'hDEADBEEF, 32'h0, 1'b0, "wr_hit"));
      ops.push_back(make_row(OP_READ,  16'h1234, 4'h0, 32'h0, 32'hB7ADB7EF, 1'b0, "rd_merged"));
      // Set 5 with tags 21, 43 and 65
      ops.push_back(make_row(OP_READ,  16'h2150, 4'h0, 32'h0, 32'h84F584F5, 1'b1, "rd_a_miss"));
      ops.push_back(make_row(OP_READ,  16'h4354, 4'h0, 32'h0, 32'hE6F1E6F1, 1'b1, "rd_b_miss"));
      ops.push_back(make_row(OP_READ,  16'h2158, 4'h0, 32'h0, 32'h84FD84FD, 1'b0, "rd_a_hit"));
      // LRU now points at way1 which holds tag 43
      ops.push_back(make_row(OP_READ,  16'h655C, 4'h0, 32'h0, 32'hC0F9C0F9, 1'b1, "rd_c_evict"));
      ops.push_back(make_row(OP_READ,  16'h2150, 4'h0, 32'h0, 32'h84F584F5, 1'b0, "rd_a_kept"));
      ops.push_back(make_row(OP_READ,  16'h4358, 4'h0, 32'h0, 32'hE6FDE6FD, 1'b1, "rd_b_refill"));
      // Set 3 dropped along with the merged word
      ops.push_back(make_row(OP_INVAL, 16'h0030, 4'h0, 32'h0, 32'h0, 1'b0, "inv_set3"));
      ops.push_back(make_row(OP_READ,  16'h1234, 4'h0, 32'h0, 32'hB791B791, 1'b1, "rd_after_inv"));
      // Write miss merging lanes 1 and 3 over the fetched word
      ops.push_back(make_row(OP_WRITE, 16'h9A94, 4'hA, 32'h11223344, 32'h0, 1'b1, "wr_miss"));
      ops.push_back(make_row(OP_READ,  16'h9A94, 4'h0, 32'h0, 32'h11313331, 1'b0, "rd_wr_miss"));
      ops.push_back(make_row(OP_READ,  16'h9A98, 4'h0, 32'h0, 32'h3F3D3F3D, 1'b0, "rd_neighbor"));
   endtask

   // Ack seen mid-cycle and bounded by its own timeout
   task automatic wait_done(input logic inv, output logic ok);
      int cnt;
      ok  = 1'b0;
      cnt = 0;
      while (!ok && cnt < TIMEOUT_CYCLES) begin
         @(negedge clk);
         ok = inv ? inv_ack_o : ack_o;
         cnt++;
      end
      if (!ok) begin
         $display("ERROR: %s got no acknowledge within %0d cycles", cur_name, TIMEOUT_CYCLES);
      end
   endtask

   // Called just after a rising edge
   task automatic run_op(input op_row_t op, output logic ok);
      cur_name   = op.name;
      check_rdat = (op.kind == OP_READ);
      exp_rdat   = op.exp_rdat;
      exp_refill = op.exp_refill;
      // Block base, 16 bytes per block
      exp_base   = op.adr & 16'hFFF0;
      if (op.kind == OP_INVAL) begin
         inv_index = op.adr[SET_W+OFFS_W-1:OFFS_W];
         inv_i     = 1'b1;
         wait_done(1'b1, ok);
      end else begin
         req_data.adr  = op.adr;
         req_data.we   = (op.kind == OP_WRITE);
         req_data.bsel = op.bsel;
         req_data.wdat = op.wdat;
         req_i         = 1'b1;
         wait_done(1'b0, ok);
      end
      // Strobes dropped in the cycle after the ack
      @(posedge clk);
      #2;
      req_i = 1'b0;
      inv_i = 1'b0;
   endtask

   initial begin
      logic ok;
      rst         = 1'b1;
      req_i       = 1'b0;
      req_data    = '0;
      inv_i       = 1'b0;
      inv_index   = '0;
      cur_name    = "reset";
      check_rdat  = 1'b0;
      exp_rdat    = '0;
      exp_refill  = 1'b0;
      exp_base    = '0;
      timeout_cnt = 0;
      load_table();

      repeat (2) @(posedge clk);
      #2;
      rst = 1'b0;

      // Requests queue behind the tag sweep
      for (int i = 0; i < ops.size() && timeout_cnt == 0; i++) begin
         run_op(ops[i], ok);
         if (!ok) begin
            timeout_cnt++;
         end
      end

      repeat (2) @(posedge clk);
      $display("Operations: %0d of %0d, mismatches: %0d, timeouts: %0d",
               done_cnt, ops.size(), err_cnt, timeout_cnt);
      if (err_cnt == 0 && timeout_cnt == 0 && done_cnt == ops.size()) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule
